// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    // ------------------------------
    // Datapath word

    localparam int WORD_WIDTH = 16;

    // ------------------------------
    // I/O ports with the same count on the A and B sides

    localparam int IO_PORT_COUNT    = 4;
    localparam int PORT_INDEX_WIDTH = $clog2(IO_PORT_COUNT);

    // One word per port with port 0 in the low bits
    localparam int IO_DATA_WIDTH = IO_PORT_COUNT * WORD_WIDTH;

    // ------------------------------
    // Result write address

    localparam int WRITE_ADDR_WIDTH = 12;

    // Port k sits at base plus k
    localparam logic [WRITE_ADDR_WIDTH-1:0] IO_PORT_BASE_ADDR = 12'd28;

endpackage

`default_nettype wire

// ==== harness_pkg.sv ====
`default_nettype none

package harness_pkg;

    import core_pkg::*;

    // Frame period in clocks and never shorter than either frame
    localparam int FRAME_LEN         = 176;
    localparam int FRAME_COUNT_WIDTH = $clog2(FRAME_LEN);

    // External selects, four flag groups, two read data groups
    localparam int INPUT_WIDTH = 2 + (4 * IO_PORT_COUNT) + (2 * IO_DATA_WIDTH);

    // Two write data groups, four enable groups, rb and its address
    localparam int OUTPUT_WIDTH = (2 * IO_DATA_WIDTH) + (4 * IO_PORT_COUNT)
                                + WORD_WIDTH + WRITE_ADDR_WIDTH;

endpackage

`default_nettype wire

// ==== harness_input_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module harness_input_register (
    input  wire logic                               clock,
    input  wire logic                               arst_n,
    input  wire logic                               test_in,
    output logic [harness_pkg::INPUT_WIDTH-1:0]     frame,
    output logic                                    frame_strobe
);

    import harness_pkg::*;

    logic [FRAME_COUNT_WIDTH-1:0]   frame_count_q;
    logic [INPUT_WIDTH-1:0]         shift_q;
    logic [INPUT_WIDTH-1:0]         shift_next;
    logic                           last_count;

    // First bit in ends up as the MSB
    assign shift_next = {shift_q[INPUT_WIDTH-2:0], test_in};
    assign last_count = (frame_count_q == FRAME_COUNT_WIDTH'(FRAME_LEN - 1));

    // ------------------------------
    // Frame counter, strobe and shadow copy

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            frame_count_q <= '0;
            frame_strobe  <= 1'b0;
            frame         <= '0;
        end else begin
            frame_strobe <= last_count;
            if (last_count) begin
                frame_count_q <= '0;
                frame         <= shift_next;
            end else begin
                frame_count_q <= frame_count_q + 1'b1;
            end
        end
    end

    // ------------------------------
    // Serial shift

    always_ff @(posedge clock) begin
        shift_q <= shift_next;
    end

    // Strobe is a single-cycle pulse once per frame
    a_strobe_single: assert property (
        @(posedge clock) disable iff (!arst_n)
        frame_strobe |=> !frame_strobe
    );

endmodule

`default_nettype wire

// ==== harness_output_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module harness_output_register (
    input  wire logic                                   clock,
    input  wire logic                                   arst_n,
    input  wire logic                                   frame_strobe,
    input  wire logic [harness_pkg::OUTPUT_WIDTH-1:0]   frame,
    output logic                                        test_out
);

    import harness_pkg::*;

    logic [OUTPUT_WIDTH-1:0] shift_q;

    // ------------------------------
    // Parallel load and serial out

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            shift_q <= '0;
        end else if (frame_strobe) begin
            shift_q <= frame;
        end else begin
            // Zeros trail the frame until the next load
            shift_q <= {shift_q[OUTPUT_WIDTH-2:0], 1'b0};
        end
    end

    // MSB first
    assign test_out = shift_q[OUTPUT_WIDTH-1];

endmodule

`default_nettype wire

// ==== io_port_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_port_core (
    input  wire logic                                   clock,
    input  wire logic                                   arst_n,
    input  wire logic                                   step,

    input  wire logic                                   a_external,
    input  wire logic                                   b_external,

    input  wire logic [core_pkg::IO_PORT_COUNT-1:0]     io_read_ef_a,
    input  wire logic [core_pkg::IO_PORT_COUNT-1:0]     io_read_ef_b,
    input  wire logic [core_pkg::IO_PORT_COUNT-1:0]     io_write_ef_a,
    input  wire logic [core_pkg::IO_PORT_COUNT-1:0]     io_write_ef_b,

    input  wire logic [core_pkg::IO_DATA_WIDTH-1:0]     io_read_data_a,
    input  wire logic [core_pkg::IO_DATA_WIDTH-1:0]     io_read_data_b,
    output logic      [core_pkg::IO_DATA_WIDTH-1:0]     io_write_data_a,
    output logic      [core_pkg::IO_DATA_WIDTH-1:0]     io_write_data_b,

    output logic      [core_pkg::IO_PORT_COUNT-1:0]     io_rden_a,
    output logic      [core_pkg::IO_PORT_COUNT-1:0]     io_rden_b,
    output logic      [core_pkg::IO_PORT_COUNT-1:0]     io_wren_a,
    output logic      [core_pkg::IO_PORT_COUNT-1:0]     io_wren_b,

    output logic      [core_pkg::WORD_WIDTH-1:0]        rb,
    output logic      [core_pkg::WRITE_ADDR_WIDTH-1:0]  write_addr_rb
);

    import core_pkg::*;

    logic [PORT_INDEX_WIDTH-1:0]    port_index_q;
    logic [WORD_WIDTH-1:0]          acc_q [IO_PORT_COUNT];
    logic [WORD_WIDTH-1:0]          read_word_a;
    logic [WORD_WIDTH-1:0]          read_word_b;
    logic                           port_ready;

    logic                           step_q;
    logic                           exec_q;
    logic [PORT_INDEX_WIDTH-1:0]    exec_port_q;
    logic [WORD_WIDTH-1:0]          operand_a_q;
    logic [WORD_WIDTH-1:0]          operand_b_q;

    logic [WORD_WIDTH-1:0]          sum;
    logic [IO_PORT_COUNT-1:0]       port_onehot;
    logic                           exec_fire;

    // ------------------------------
    // Port select

    assign read_word_a = io_read_data_a[port_index_q*WORD_WIDTH +: WORD_WIDTH];
    assign read_word_b = io_read_data_b[port_index_q*WORD_WIDTH +: WORD_WIDTH];

    // Both reads have data and both writes have space
    assign port_ready = io_read_ef_a[port_index_q] & io_read_ef_b[port_index_q]
                      & io_write_ef_a[port_index_q] & io_write_ef_b[port_index_q];

    // ------------------------------
    // Stage 1 captures operands and the execute decision

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            port_index_q <= '0;
            step_q       <= 1'b0;
            exec_q       <= 1'b0;
            exec_port_q  <= '0;
        end else begin
            step_q <= step;
            if (step) begin
                // Rotate even when the step stalls
                port_index_q <= port_index_q + 1'b1;
                exec_q       <= port_ready;
                exec_port_q  <= port_index_q;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (step) begin
            operand_a_q <= a_external ? read_word_a : acc_q[port_index_q];
            operand_b_q <= b_external ? read_word_b : acc_q[port_index_q];
        end
    end

    // ------------------------------
    // Stage 2 registers the results

    assign sum       = operand_a_q + operand_b_q;
    assign exec_fire = step_q & exec_q;

    always_comb begin
        for (int k = 0; k < IO_PORT_COUNT; k++) begin
            port_onehot[k] = (exec_port_q == PORT_INDEX_WIDTH'(k));
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            io_rden_a       <= '0;
            io_rden_b       <= '0;
            io_wren_a       <= '0;
            io_wren_b       <= '0;
            rb              <= '0;
            write_addr_rb   <= '0;
            io_write_data_a <= '0;
            io_write_data_b <= '0;
        end else if (step_q) begin
            // Enables held until the next step and cleared on a stall
            io_rden_a <= exec_q ? port_onehot : '0;
            io_rden_b <= exec_q ? port_onehot : '0;
            io_wren_a <= exec_q ? port_onehot : '0;
            io_wren_b <= exec_q ? port_onehot : '0;
            if (exec_q) begin
                rb            <= sum;
                write_addr_rb <= IO_PORT_BASE_ADDR
                               + {{(WRITE_ADDR_WIDTH-PORT_INDEX_WIDTH){1'b0}}, exec_port_q};
                io_write_data_a[exec_port_q*WORD_WIDTH +: WORD_WIDTH] <= sum;
                io_write_data_b[exec_port_q*WORD_WIDTH +: WORD_WIDTH] <= sum;
            end
        end
    end

    // Accumulators follow the write data of their port
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < IO_PORT_COUNT; k++) begin
                acc_q[k] <= '0;
            end
        end else if (exec_fire) begin
            acc_q[exec_port_q] <= sum;
        end
    end

    // ------------------------------
    // Port handshake checks

    a_rden_onehot: assert property (
        @(posedge clock) disable iff (!arst_n)
        $onehot0(io_rden_a) && $onehot0(io_rden_b)
    );

    a_wren_needs_rden: assert property (
        @(posedge clock) disable iff (!arst_n)
        ((io_wren_a & ~io_rden_a) == '0) && ((io_wren_b & ~io_rden_b) == '0)
    );

endmodule

`default_nettype wire

// ==== core_harness_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_harness_top (
    input  wire logic   clock,
    input  wire logic   arst_n,
    input  wire logic   test_in,
    output logic        test_out
);

    import core_pkg::*;
    import harness_pkg::*;

    logic [INPUT_WIDTH-1:0]         test_input;
    logic [OUTPUT_WIDTH-1:0]        test_output;
    logic                           frame_strobe;

    logic                           a_external;
    logic                           b_external;
    logic [IO_PORT_COUNT-1:0]       io_read_ef_a;
    logic [IO_PORT_COUNT-1:0]       io_read_ef_b;
    logic [IO_PORT_COUNT-1:0]       io_write_ef_a;
    logic [IO_PORT_COUNT-1:0]       io_write_ef_b;
    logic [IO_DATA_WIDTH-1:0]       io_read_data_a;
    logic [IO_DATA_WIDTH-1:0]       io_read_data_b;

    logic [IO_DATA_WIDTH-1:0]       io_write_data_a;
    logic [IO_DATA_WIDTH-1:0]       io_write_data_b;
    logic [IO_PORT_COUNT-1:0]       io_rden_a;
    logic [IO_PORT_COUNT-1:0]       io_rden_b;
    logic [IO_PORT_COUNT-1:0]       io_wren_a;
    logic [IO_PORT_COUNT-1:0]       io_wren_b;
    logic [WORD_WIDTH-1:0]          rb;
    logic [WRITE_ADDR_WIDTH-1:0]    write_addr_rb;

    // ------------------------------
    // Frame split and join with the MSB first

    assign {a_external, b_external, io_read_ef_a, io_read_ef_b,
            io_write_ef_a, io_write_ef_b, io_read_data_a, io_read_data_b} = test_input;

    assign test_output = {io_write_data_a, io_write_data_b, io_rden_a, io_rden_b,
                          io_wren_a, io_wren_b, rb, write_addr_rb};

    // ------------------------------
    // Harness registers

    harness_input_register i (
        .clock          (clock),
        .arst_n         (arst_n),
        .test_in        (test_in),
        .frame          (test_input),
        .frame_strobe   (frame_strobe)
    );

    harness_output_register o (
        .clock          (clock),
        .arst_n         (arst_n),
        .frame_strobe   (frame_strobe),
        .frame          (test_output),
        .test_out       (test_out)
    );

    // ------------------------------
    // One core step per frame

    io_port_core core0 (
        .clock              (clock),
        .arst_n             (arst_n),
        .step               (frame_strobe),
        .a_external         (a_external),
        .b_external         (b_external),
        .io_read_ef_a       (io_read_ef_a),
        .io_read_ef_b       (io_read_ef_b),
        .io_write_ef_a      (io_write_ef_a),
        .io_write_ef_b      (io_write_ef_b),
        .io_read_data_a     (io_read_data_a),
        .io_read_data_b     (io_read_data_b),
        .io_write_data_a    (io_write_data_a),
        .io_write_data_b    (io_write_data_b),
        .io_rden_a          (io_rden_a),
        .io_rden_b          (io_rden_b),
        .io_wren_a          (io_wren_a),
        .io_wren_b          (io_wren_b),
        .rb                 (rb),
        .write_addr_rb      (write_addr_rb)
    );

endmodule

`default_nettype wire

// ==== tb_core_harness.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core_harness;

    import core_pkg::*;
    import harness_pkg::*;

    localparam int CLOCK_PERIOD_NS = 10;
    localparam int RANDOM_SEED     = 18535;

    localparam int DIRECTED_ROWS = 16;
    localparam int RANDOM_ROWS   = 8;
    localparam int ROW_COUNT     = DIRECTED_ROWS + RANDOM_ROWS;

    // Two trailing frames flush the last results out of test_out
    localparam int FRAME_COUNT = ROW_COUNT + 2;
    localparam int LEAD_BITS   = FRAME_LEN - INPUT_WIDTH;
    localparam int WATCHDOG_NS = (ROW_COUNT + 3) * FRAME_LEN * CLOCK_PERIOD_NS;

    logic clock;
    logic arst_n;
    logic test_in;
    logic test_out;

    string                      row_name   [ROW_COUNT];
    logic [INPUT_WIDTH-1:0]     row_input  [ROW_COUNT];
    logic [OUTPUT_WIDTH-1:0]    row_expect [ROW_COUNT];
    int                         row_fill;

    core_harness_top dut0 (
        .clock      (clock),
        .arst_n     (arst_n),
        .test_in    (test_in),
        .test_out   (test_out)
    );

    always #(CLOCK_PERIOD_NS / 2) clock = ~clock;

    // ------------------------------
    // Stimulus table

    function automatic logic [IO_DATA_WIDTH-1:0] pack_words(
        input logic [WORD_WIDTH-1:0] w0,
        input logic [WORD_WIDTH-1:0] w1,
        input logic [WORD_WIDTH-1:0] w2,
        input logic [WORD_WIDTH-1:0] w3
    );
        // Port 0 in the low bits
        return {w3, w2, w1, w0};
    endfunction

    function automatic logic [IO_PORT_COUNT-1:0] random_flags();
        // Mostly ready with a random pattern now and then
        if (($urandom % 4) == 0) begin
            return IO_PORT_COUNT'($urandom);
        end
        return '1;
    endfunction

    task automatic add_row(
        input string                    name,
        input logic                     a_ext,
        input logic                     b_ext,
        input logic [IO_PORT_COUNT-1:0] ef_ra,
        input logic [IO_PORT_COUNT-1:0] ef_rb,
        input logic [IO_PORT_COUNT-1:0] ef_wa,
        input logic [IO_PORT_COUNT-1:0] ef_wb,
        input logic [IO_DATA_WIDTH-1:0] data_a,
        input logic [IO_DATA_WIDTH-1:0] data_b
    );
        row_name[row_fill]  = name;
        row_input[row_fill] = {a_ext, b_ext, ef_ra, ef_rb, ef_wa, ef_wb, data_a, data_b};
        row_fill++;
    endtask

    task automatic build_table();
        logic [IO_DATA_WIDTH-1:0] base_a;
        logic [IO_DATA_WIDTH-1:0] base_b;
        logic [IO_DATA_WIDTH-1:0] acc_data;
        logic [IO_PORT_COUNT-1:0] rdy;
        rdy      = '1;
        row_fill = 0;
        // Port 3 sum wraps past 16 bits
        base_a = pack_words(16'h0011, 16'h0022, 16'h0033, 16'hfff0);
        base_b = pack_words(16'h1000, 16'h2000, 16'h3000, 16'h0025);

        add_row("all_ready_p0", 1'b1, 1'b1, rdy, rdy, rdy, rdy, base_a, base_b);
        add_row("all_ready_p1", 1'b1, 1'b1, rdy, rdy, rdy, rdy, base_a, base_b);
        add_row("all_ready_p2", 1'b1, 1'b1, rdy, rdy, rdy, rdy, base_a, base_b);
        add_row("all_ready_p3", 1'b1, 1'b1, rdy, rdy, rdy, rdy, base_a, base_b);

        // One missing flag at the current port
        add_row("stall_read_a_p0", 1'b1, 1'b1, 4'b1110, rdy, rdy, rdy, base_b, base_a);
        add_row("stall_write_b_p1", 1'b1, 1'b1, rdy, rdy, rdy, 4'b1101, base_b, base_a);
        add_row("ready_p2", 1'b1, 1'b1, rdy, rdy, rdy, rdy,
                pack_words(16'h0001, 16'h0002, 16'h0400, 16'h0008),
                pack_words(16'h0010, 16'h0020, 16'h0055, 16'h0080));
        add_row("stall_read_b_p3", 1'b1, 1'b1, rdy, 4'b0111, rdy, rdy, base_a, base_b);

        // Operand A from the accumulator over two rounds on every port
        for (int k = 0; k < 8; k++) begin
            acc_data = {IO_PORT_COUNT{WORD_WIDTH'(16'h0203 * (k + 1))}};
            add_row($sformatf("accumulate_%0d", k), 1'b0, 1'b1, rdy, rdy, rdy, rdy,
                    64'hdead_beef_cafe_f00d, acc_data);
        end

        for (int k = 0; k < RANDOM_ROWS; k++) begin
            add_row($sformatf("random_%0d", k), 1'($urandom), 1'($urandom),
                    random_flags(), random_flags(), random_flags(), random_flags(),
                    {$urandom, $urandom}, {$urandom, $urandom});
        end
    endtask

    // ------------------------------
    // Reference model

    task automatic compute_expected();
        logic [WORD_WIDTH-1:0]       acc     [IO_PORT_COUNT];
        logic [WORD_WIDTH-1:0]       wdata_a [IO_PORT_COUNT];
        logic [WORD_WIDTH-1:0]       wdata_b [IO_PORT_COUNT];
        logic [WORD_WIDTH-1:0]       model_rb;
        logic [WRITE_ADDR_WIDTH-1:0] model_addr;
        logic [IO_PORT_COUNT-1:0]    enables;
        logic [IO_DATA_WIDTH-1:0]    packed_a;
        logic [IO_DATA_WIDTH-1:0]    packed_b;
        logic                        a_ext;
        logic                        b_ext;
        logic [IO_PORT_COUNT-1:0]    ef_ra;
        logic [IO_PORT_COUNT-1:0]    ef_rb;
        logic [IO_PORT_COUNT-1:0]    ef_wa;
        logic [IO_PORT_COUNT-1:0]    ef_wb;
        logic [IO_DATA_WIDTH-1:0]    data_a;
        logic [IO_DATA_WIDTH-1:0]    data_b;
        logic [WORD_WIDTH-1:0]       op_a;
        logic [WORD_WIDTH-1:0]       op_b;
        logic [WORD_WIDTH-1:0]       sum;
        int                          p;
        p          = 0;
        model_rb   = '0;
        model_addr = '0;
        for (int k = 0; k < IO_PORT_COUNT; k++) begin
            acc[k]     = '0;
            wdata_a[k] = '0;
            wdata_b[k] = '0;
        end
        for (int r = 0; r < ROW_COUNT; r++) begin
            {a_ext, b_ext, ef_ra, ef_rb, ef_wa, ef_wb, data_a, data_b} = row_input[r];
            enables = '0;
            if (ef_ra[p] && ef_rb[p] && ef_wa[p] && ef_wb[p]) begin
                op_a       = a_ext ? data_a[p*WORD_WIDTH +: WORD_WIDTH] : acc[p];
                op_b       = b_ext ? data_b[p*WORD_WIDTH +: WORD_WIDTH] : acc[p];
                sum        = op_a + op_b;
                model_rb   = sum;
                model_addr = IO_PORT_BASE_ADDR + WRITE_ADDR_WIDTH'(p);
                wdata_a[p] = sum;
                wdata_b[p] = sum;
                acc[p]     = sum;
                enables[p] = 1'b1;
            end
            for (int k = 0; k < IO_PORT_COUNT; k++) begin
                packed_a[k*WORD_WIDTH +: WORD_WIDTH] = wdata_a[k];
                packed_b[k*WORD_WIDTH +: WORD_WIDTH] = wdata_b[k];
            end
            row_expect[r] = {packed_a, packed_b, enables, enables, enables, enables,
                             model_rb, model_addr};
            p = (p + 1) % IO_PORT_COUNT;
        end
    endtask

    // ------------------------------
    // Serial frame driver and collector

    task automatic run_frame(
        input  logic [INPUT_WIDTH-1:0]  in_frame,
        output logic [OUTPUT_WIDTH-1:0] out_frame
    );
        out_frame = '0;
        for (int c = 0; c < FRAME_LEN; c++) begin
            if (c < LEAD_BITS) begin
                test_in <= 1'b0;
            end else begin
                test_in <= in_frame[INPUT_WIDTH - 1 - (c - LEAD_BITS)];
            end
            @(negedge clock);
            // Bit c-1 of the loaded frame sits on test_out here
            if (c >= 1 && c <= OUTPUT_WIDTH) begin
                out_frame[OUTPUT_WIDTH - c] = test_out;
            end
            @(posedge clock);
        end
    endtask

    // ------------------------------
    // Main sequence

    initial begin
        logic [INPUT_WIDTH-1:0]  send_frame;
        logic [OUTPUT_WIDTH-1:0] got_frame;
        logic [OUTPUT_WIDTH-1:0] want_frame;
        string                   check_name;
        int                      seed_value;
        clock      = 1'b0;
        arst_n     = 1'b0;
        test_in    = 1'b0;
        seed_value = $urandom(RANDOM_SEED);

        build_table();
        compute_expected();

        repeat (2) @(posedge clock);
        arst_n <= 1'b1;

        for (int n = 0; n < FRAME_COUNT; n++) begin
            send_frame = (n < ROW_COUNT) ? row_input[n] : '0;
            run_frame(send_frame, got_frame);
            // Output of row r is shifted out two frames later
            if (n >= 1) begin
                if (n < 2) begin
                    check_name = "after_reset";
                    want_frame = '0;
                end else begin
                    check_name = row_name[n - 2];
                    want_frame = row_expect[n - 2];
                end
                assert (got_frame == want_frame) else begin
                    $display("ERROR %s expected %h actual %h", check_name, want_frame,
                             got_frame);
                    $display("Done: errors found");
                    $fatal(1, "output frame mismatch");
                end
            end
        end

        $display("Done: no errors");
        $finish;
    end

    // ------------------------------
    // Watchdog

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
core_pkg.sv
harness_pkg.sv
harness_input_register.sv
harness_output_register.sv
io_port_core.sv
core_harness_top.sv
tb_core_harness.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_core_harness
FILELIST  = filelist.f

BUILD_DIR = obj_dir
LOG       = sim.log
SOURCES   = $(filter-out +%,$(shell cat $(FILELIST)))
BIN       = $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx 'Done: no errors' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
